// ==== Bender.yml ====
package:
  name: i2s_dsp_rx

sources:
  # Receiver RTL in compile order
  - files:
      - design/i2s_dsp_pkg.sv
      - design/i2s_dsp_frame_ctrl.sv
      - design/i2s_dsp_deser.sv
      - design/i2s_dsp_out_stage.sv
      - design/i2s_dsp_rx.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_i2s_dsp_rx.sv

# Top modules: tb_i2s_dsp_rx for simulation, i2s_dsp_rx for synthesis

// ==== design/i2s_dsp_deser.sv ====
`timescale 1ns/1ps

module i2s_dsp_deser (
    input  logic                            sck_i,
    input  logic                            rstn_i,
    input  logic                            sd_i,
    input  i2s_dsp_pkg::shift_ctl_t         ctl_i,
    input  i2s_dsp_pkg::rx_cfg_t            cfg_i,
    output logic [i2s_dsp_pkg::DATA_W-1:0]  data_o
);
    import i2s_dsp_pkg::*;

    logic [DATA_W-1:0] shift_q;
    logic [DATA_W-1:0] shift_d;
    logic [DATA_W-1:0] base;
    logic [DATA_W-1:0] aligned;
    logic [CNT_W-1:0]  pad_bits;

    // Unused upper bits of the register for this word length
    always_comb begin
        case (cfg_i.word_len)
            WLEN_8:  pad_bits = CNT_W'(24);
            WLEN_16: pad_bits = CNT_W'(16);
            WLEN_24: pad_bits = CNT_W'(8);
            default: pad_bits = CNT_W'(0);
        endcase
    end

    // Start from an empty register on the first bit so short words come out zero-extended
    assign base = ctl_i.first ? '0 : shift_q;

    always_comb begin
        if (cfg_i.lsb_first) begin
            // LSB first enters at the top and moves down
            shift_d = {sd_i, base[DATA_W-1:1]};
        end else begin
            shift_d = {base[DATA_W-2:0], sd_i};
        end
    end

    // LSB-first words sit at the top, bring the first bit down to bit 0
    assign aligned = cfg_i.lsb_first ? (shift_d >> pad_bits) : shift_d;

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            shift_q <= '0;
        end else if (ctl_i.sample) begin
            shift_q <= shift_d;
        end
    end

    // Finished word, stays put while the next word shifts in
    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            data_o <= '0;
        end else if (ctl_i.sample && ctl_i.last) begin
            data_o <= aligned;
        end
    end

endmodule

// ==== design/i2s_dsp_frame_ctrl.sv ====
`timescale 1ns/1ps

module i2s_dsp_frame_ctrl (
    input  logic                    sck_i,
    input  logic                    rstn_i,
    input  logic                    ws_i,
    input  i2s_dsp_pkg::rx_cfg_t    cfg_i,
    input  logic                    busy_i,
    output i2s_dsp_pkg::shift_ctl_t ctl_o
);
    import i2s_dsp_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        OFFSET,
        RUN
    } state_e;

    state_e           state_q;
    state_e           state_d;
    logic [CNT_W-1:0] off_cnt_q;
    logic [CNT_W-1:0] bit_cnt_q;
    logic [CNT_W-1:0] last_idx;
    logic             start;

    // Index of the final bit within a word
    always_comb begin
        case (cfg_i.word_len)
            WLEN_8:  last_idx = CNT_W'(7);
            WLEN_16: last_idx = CNT_W'(15);
            WLEN_24: last_idx = CNT_W'(23);
            default: last_idx = CNT_W'(31);
        endcase
    end

    // Frame sync is only accepted once the output stage has drained
    assign start = cfg_i.en && ws_i && !busy_i;

    always_comb begin
        state_d = state_q;
        ctl_o   = '0;
        case (state_q)
            IDLE: begin
                if (start) begin
                    if (cfg_i.offset == '0) begin
                        // No offset, the bit on the line right now is the first one
                        ctl_o.sample = 1'b1;
                        ctl_o.first  = 1'b1;
                        state_d      = RUN;
                    end else begin
                        state_d = OFFSET;
                    end
                end
            end
            OFFSET: begin
                if (!cfg_i.en) begin
                    state_d = IDLE;
                end else if (off_cnt_q == cfg_i.offset) begin
                    ctl_o.sample = 1'b1;
                    ctl_o.first  = 1'b1;
                    state_d      = RUN;
                end
            end
            RUN: begin
                if (!cfg_i.en) begin
                    state_d = IDLE;
                end else begin
                    ctl_o.sample = 1'b1;
                    if (bit_cnt_q == last_idx) begin
                        ctl_o.last = 1'b1;
                        state_d    = IDLE;
                    end
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= IDLE;
            off_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else begin
            state_q <= state_d;

            // Offset edges counted from the sync edge onwards
            if (state_q == IDLE) begin
                off_cnt_q <= CNT_W'(1);
            end else if (state_q == OFFSET) begin
                off_cnt_q <= off_cnt_q + 1'b1;
            end

            // The first bit counts as bit 0, so the counter restarts at 1
            if (ctl_o.first) begin
                bit_cnt_q <= CNT_W'(1);
            end else if (ctl_o.sample) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

endmodule

// ==== design/i2s_dsp_out_stage.sv ====
`timescale 1ns/1ps

module i2s_dsp_out_stage (
    input  logic                            sck_i,
    input  logic                            rstn_i,
    input  logic                            load_i,
    input  logic                            two_ch_i,
    input  logic [i2s_dsp_pkg::DATA_W-1:0]  ch0_i,
    input  logic [i2s_dsp_pkg::DATA_W-1:0]  ch1_i,
    output i2s_dsp_pkg::rx_word_t           word_o,
    output logic                            valid_o,
    input  logic                            ready_i,
    output logic                            busy_o
);
    import i2s_dsp_pkg::*;

    logic              load_q;
    logic              pend_ch0_q;
    logic              pend_ch1_q;
    logic [DATA_W-1:0] data_ch0_q;
    logic [DATA_W-1:0] data_ch1_q;
    logic              xfer;

    assign xfer = valid_o && ready_i;

    // Deserializer words settle one edge after the last strobe
    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load_i;
        end
    end

    always_ff @(posedge sck_i) begin
        if (load_q) begin
            data_ch0_q <= ch0_i;
            data_ch1_q <= ch1_i;
        end
    end

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pend_ch0_q <= 1'b0;
            pend_ch1_q <= 1'b0;
        end else if (load_q) begin
            pend_ch0_q <= 1'b1;
            pend_ch1_q <= two_ch_i;
        end else if (xfer) begin
            // Channel 0 always leaves first
            if (pend_ch0_q) begin
                pend_ch0_q <= 1'b0;
            end else begin
                pend_ch1_q <= 1'b0;
            end
        end
    end

    assign valid_o     = pend_ch0_q || pend_ch1_q;
    assign word_o.data = pend_ch0_q ? data_ch0_q : data_ch1_q;
    assign word_o.ch   = !pend_ch0_q;

    // Keeps the controller from taking a new frame until everything is out
    assign busy_o = load_q || pend_ch0_q || pend_ch1_q;

endmodule

// ==== design/i2s_dsp_pkg.sv ====
package i2s_dsp_pkg;

    // Output word width and counter width
    localparam int DATA_W = 32;
    localparam int CNT_W  = 5;

    // Supported word lengths
    typedef enum logic [1:0] {
        WLEN_8  = 2'd0,
        WLEN_16 = 2'd1,
        WLEN_24 = 2'd2,
        WLEN_32 = 2'd3
    } word_len_e;

    // Receiver configuration, only changed while en is low
    typedef struct packed {
        logic             en;
        logic             two_ch;
        logic             lsb_first;
        word_len_e        word_len;
        logic [CNT_W-1:0] offset;
    } rx_cfg_t;

    // Strobes from the frame controller to the deserializers
    typedef struct packed {
        // Take a bit on this edge
        logic sample;
        // Bit starts a new word
        logic first;
        // Bit completes the word
        logic last;
    } shift_ctl_t;

    // Word on the output port, tagged with its channel
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              ch;
    } rx_word_t;

endpackage

// ==== design/i2s_dsp_rx.sv ====
`timescale 1ns/1ps

module i2s_dsp_rx (
    input  logic                  sck_i,
    input  logic                  rstn_i,
    input  logic                  ws_i,
    input  logic                  sd_ch0_i,
    input  logic                  sd_ch1_i,
    input  i2s_dsp_pkg::rx_cfg_t  cfg_i,
    output i2s_dsp_pkg::rx_word_t word_o,
    output logic                  valid_o,
    input  logic                  ready_i
);
    import i2s_dsp_pkg::*;

    shift_ctl_t        shift_ctl;
    logic [DATA_W-1:0] data_ch0;
    logic [DATA_W-1:0] data_ch1;
    logic              busy;

    // Frame sync, offset and bit timing
    i2s_dsp_frame_ctrl u_frame_ctrl (
        .sck_i  (sck_i),
        .rstn_i (rstn_i),
        .ws_i   (ws_i),
        .cfg_i  (cfg_i),
        .busy_i (busy),
        .ctl_o  (shift_ctl)
    );

    i2s_dsp_deser u_deser_ch0 (
        .sck_i  (sck_i),
        .rstn_i (rstn_i),
        .sd_i   (sd_ch0_i),
        .ctl_i  (shift_ctl),
        .cfg_i  (cfg_i),
        .data_o (data_ch0)
    );

    // Runs in single-channel mode too, its word is just never flagged
    i2s_dsp_deser u_deser_ch1 (
        .sck_i  (sck_i),
        .rstn_i (rstn_i),
        .sd_i   (sd_ch1_i),
        .ctl_i  (shift_ctl),
        .cfg_i  (cfg_i),
        .data_o (data_ch1)
    );

    i2s_dsp_out_stage u_out_stage (
        .sck_i    (sck_i),
        .rstn_i   (rstn_i),
        .load_i   (shift_ctl.last),
        .two_ch_i (cfg_i.two_ch),
        .ch0_i    (data_ch0),
        .ch1_i    (data_ch1),
        .word_o   (word_o),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .busy_o   (busy)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic sck_o,
    output logic rstn_o
);

    // 10 ns clock period
    initial begin
        sck_o = 1'b0;
        forever begin
            #5 sck_o = ~sck_o;
        end
    end

    // Reset held for the first 16 rising edges
    initial begin
        rstn_o = 1'b0;
        repeat (16) @(posedge sck_o);
        rstn_o <= 1'b1;
    end

endmodule

// ==== sim/tb_i2s_dsp_rx.sv ====
`timescale 1ns/1ps

module tb_i2s_dsp_rx;
    import i2s_dsp_pkg::*;

    localparam int FRAMES_MSB    = 4;
    localparam int FRAMES_LSB    = 8;
    localparam int FRAMES_OFFSET = 12;
    localparam int FRAMES_BP     = 10;
    localparam int IDLE_PULSES   = 5;
    // Longest frame from sync to valid, with some margin
    localparam int SETTLE_CYCLES = (2 ** CNT_W) + DATA_W + 4;
    // The enable-low test counts as two frames, its idle phase and one real frame
    localparam int NUM_FRAMES    = FRAMES_MSB + FRAMES_LSB + FRAMES_OFFSET + FRAMES_BP + 2;
    localparam int CYCLE_LIMIT   = 300 * NUM_FRAMES;

    logic     sck;
    logic     rstn;
    logic     ws;
    logic     sd_ch0;
    logic     sd_ch1;
    rx_cfg_t  cfg;
    rx_word_t word;
    logic     valid;
    logic     ready;

    integer   seed;
    rx_word_t exp_q[$];
    string    cur_test;
    int       err_cnt;
    int       check_cnt;
    int       words_rx;
    int       valid_cycles;
    int       stall_pulses;
    int       cycle_cnt;
    int       test_err0;
    int       test_words0;
    int       test_frames;
    int       hold_cnt;
    bit       bp_mode;
    bit       stall_q;
    rx_word_t held_word;

    tb_clk_gen u_clk_gen (
        .sck_o  (sck),
        .rstn_o (rstn)
    );

    i2s_dsp_rx UUT (
        .sck_i    (sck),
        .rstn_i   (rstn),
        .ws_i     (ws),
        .sd_ch0_i (sd_ch0),
        .sd_ch1_i (sd_ch1),
        .cfg_i    (cfg),
        .word_o   (word),
        .valid_o  (valid),
        .ready_i  (ready)
    );

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        check_cnt++;
        if (exp_v !== act_v) begin
            $display("ERR %s expected %0h actual %0h", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    function automatic int word_bits(input word_len_e wl);
        case (wl)
            WLEN_8:  return 8;
            WLEN_16: return 16;
            WLEN_24: return 24;
            default: return 32;
        endcase
    endfunction

    // Advance one rising edge and update ready, random stretches under back-pressure
    task automatic next_edge();
        @(posedge sck);
        if (bp_mode) begin
            if (hold_cnt == 0) begin
                ready    <= 1'($random(seed));
                hold_cnt = 1 + ($unsigned($random(seed)) % 8);
            end else begin
                hold_cnt--;
            end
        end else begin
            ready <= 1'b1;
        end
    endtask

    task automatic run_frame(input logic two_ch, input logic lsb, input word_len_e wl,
                             input logic [CNT_W-1:0] off, input bit ws_in_stall);
        int                n;
        int                k;
        int                idx;
        bit                ws_sent;
        logic [DATA_W-1:0] mask;
        logic [DATA_W-1:0] w0;
        logic [DATA_W-1:0] w1;
        rx_cfg_t           c;
        rx_word_t          exp_w;
        n    = word_bits(wl);
        mask = {DATA_W{1'b1}} >> (DATA_W - n);
        w0   = $random(seed) & mask;
        w1   = $random(seed) & mask;
        c.en        = 1'b0;
        c.two_ch    = two_ch;
        c.lsb_first = lsb;
        c.word_len  = wl;
        c.offset    = off;
        next_edge();
        cfg <= c;
        next_edge();
        cfg.en <= 1'b1;
        exp_w.data = w0;
        exp_w.ch   = 1'b0;
        exp_q.push_back(exp_w);
        if (two_ch) begin
            exp_w.data = w1;
            exp_w.ch   = 1'b1;
            exp_q.push_back(exp_w);
        end
        // Step 0 carries the sync pulse, bit i is on the line at step off + i
        for (k = 0; k < int'(off) + n; k++) begin
            next_edge();
            ws <= (k == 0);
            if (k < int'(off)) begin
                sd_ch0 <= 1'($random(seed));
                sd_ch1 <= 1'($random(seed));
            end else begin
                idx = lsb ? (k - int'(off)) : (n - 1 - (k - int'(off)));
                sd_ch0 <= w0[idx];
                sd_ch1 <= w1[idx];
            end
        end
        next_edge();
        ws     <= 1'b0;
        sd_ch0 <= 1'($random(seed));
        sd_ch1 <= 1'($random(seed));
        ws_sent = 1'b0;
        while (exp_q.size() != 0) begin
            next_edge();
            ws <= 1'b0;
            // Sync pulse while the output is stalled must be dropped
            if (ws_in_stall && stall_q && !ws_sent) begin
                ws      <= 1'b1;
                ws_sent = 1'b1;
            end
        end
        if (ws_sent) begin
            stall_pulses++;
            // Room for a wrongly accepted frame to finish and show up as an extra word
            repeat (SETTLE_CYCLES) next_edge();
        end
        test_frames++;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_err0   = err_cnt;
        test_words0 = words_rx;
        test_frames = 0;
    endtask

    task automatic finish_test();
        $display("Test %-12s frames %0d words %0d errors %0d", cur_test, test_frames,
                 words_rx - test_words0, err_cnt - test_err0);
    endtask

    // Output monitor, samples at the falling edge where everything is settled
    always @(negedge sck) begin
        if (rstn) begin
            if (stall_q) begin
                check_value({cur_test, "_hold_valid"}, 64'd1, valid);
                check_value({cur_test, "_hold_word"}, held_word, word);
            end
            if (valid) begin
                valid_cycles++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected word %0h on the output port in test %s",
                             word, cur_test);
                    err_cnt++;
                end else if (ready) begin
                    check_value({cur_test, "_word"}, exp_q.pop_front(), word);
                    words_rx++;
                end
            end
            stall_q   = valid && !ready;
            held_word = word;
        end
    end

    always @(posedge sck) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in test %s, %0d words never arrived",
                     cycle_cnt, cur_test, exp_q.size());
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int        cnt0;
        word_len_e wl;
        seed         = 60947;
        ws           = 1'b0;
        sd_ch0       = 1'b0;
        sd_ch1       = 1'b0;
        cfg          = '0;
        ready        = 1'b0;
        bp_mode      = 1'b0;
        hold_cnt     = 0;
        stall_q      = 1'b0;
        valid_cycles = 0;
        stall_pulses = 0;
        cur_test     = "reset";
        wait (rstn == 1'b1);
        @(negedge sck);
        check_value("reset_valid", 64'd0, valid);

        start_test("msb_single");
        for (int i = 0; i < FRAMES_MSB; i++) begin
            wl = word_len_e'(i);
            run_frame(1'b0, 1'b0, wl, '0, 1'b0);
        end
        finish_test();

        start_test("lsb_two_ch");
        for (int i = 0; i < FRAMES_LSB; i++) begin
            wl = word_len_e'($unsigned($random(seed)) % 4);
            run_frame(1'b1, 1'b1, wl, '0, 1'b0);
        end
        finish_test();

        start_test("offset");
        for (int i = 0; i < FRAMES_OFFSET; i++) begin
            wl = word_len_e'($unsigned($random(seed)) % 4);
            run_frame(1'($random(seed)), 1'($random(seed)), wl, CNT_W'($random(seed)), 1'b0);
        end
        finish_test();

        start_test("backpressure");
        bp_mode = 1'b1;
        for (int i = 0; i < FRAMES_BP; i++) begin
            wl = word_len_e'($unsigned($random(seed)) % 4);
            run_frame(1'($random(seed)), 1'($random(seed)), wl, CNT_W'($random(seed)), 1'b1);
        end
        bp_mode = 1'b0;
        if (stall_pulses == 0) begin
            $display("No sync pulse was sent during a stall in test %s", cur_test);
            err_cnt++;
        end
        finish_test();

        start_test("enable_low");
        cnt0 = valid_cycles;
        next_edge();
        cfg.en <= 1'b0;
        repeat (IDLE_PULSES) begin
            next_edge();
            ws     <= 1'b1;
            sd_ch0 <= 1'($random(seed));
            sd_ch1 <= 1'($random(seed));
            repeat (4) begin
                next_edge();
                ws <= 1'b0;
            end
        end
        repeat (40) next_edge();
        check_value("enable_low_valid", cnt0, valid_cycles);
        wl = word_len_e'($unsigned($random(seed)) % 4);
        run_frame(1'b1, 1'($random(seed)), wl, CNT_W'($random(seed)), 1'b0);
        finish_test();

        repeat (4) next_edge();
        $display("Summary: %0d checks, %0d words, %0d errors", check_cnt, words_rx, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/i2s_dsp_pkg.sv
design/i2s_dsp_frame_ctrl.sv
design/i2s_dsp_deser.sv
design/i2s_dsp_out_stage.sv
design/i2s_dsp_rx.sv
sim/tb_clk_gen.sv
sim/tb_i2s_dsp_rx.sv
